/* verilog/vdp_pkg.sv */
// VDP shared definitions

package vdp_pkg;

    // ******************************
    // Control registers
    // ******************************

    // The VDP exposes eight byte-wide control registers
    localparam int NUM_REGS = 8;

    // Bit positions inside R1
    // Interrupt enable for the end-of-frame flag
    localparam int R1_IE_BIT    = 5;
    // Screen enable where a one shows the picture and a zero shows only backdrop
    localparam int R1_BLANK_BIT = 6;

    // In the second host byte this bit marks a register write
    // When it is clear the pair is a VRAM address setup
    localparam int CMD_REG_BIT  = 7;

    // The full register file with r0 in the upper byte
    typedef struct packed {
        logic [7:0] r0;
        logic [7:0] r1;
        logic [7:0] r2;
        logic [7:0] r3;
        logic [7:0] r4;
        logic [7:0] r5;
        logic [7:0] r6;
        logic [7:0] r7;     // low nibble is the backdrop colour
    } vdp_regs_t;

    // ******************************
    // Raster timing for 640x480 at 60 Hz
    // ******************************

    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_TOTAL  = 800;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 525;

    // Both counters fit in ten bits
    localparam int CNT_W    = 10;

    // The 256x192 picture is doubled and centred in the active area
    localparam int WIN_X0   = 64;
    localparam int WIN_Y0   = 48;
    localparam int WIN_W    = 512;
    localparam int WIN_H    = 384;

    // Current raster position as seen by the pixel logic
    typedef struct packed {
        logic [CNT_W-1:0] col;
        logic [CNT_W-1:0] row;
        logic             vid_active;
    } raster_t;

endpackage

/* verilog/vdp_reg_ifce.sv */
// VDP control port

`timescale 1ns/1ps

module vdp_reg_ifce (
    input  logic              pxclk,
    input  logic              arst_n,
    input  logic              wr_tick,
    input  logic              rd_tick,
    input  logic [7:0]        din,
    output vdp_pkg::vdp_regs_t regs
);

    import vdp_pkg::*;

    // High once the first byte of a pair has been taken
    logic second_byte;

    // First byte of the pair held until the command byte arrives
    logic [7:0] data_latch;

    // Register number carried in the low bits of the command byte
    logic [$clog2(NUM_REGS)-1:0] reg_sel;

    assign reg_sel = din[$clog2(NUM_REGS)-1:0];

    // ******************************
    // Byte toggle and data latch
    // ******************************

    // A status read always restarts the pair, so a host that lost
    // track of the toggle can resync by reading status first
    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            second_byte <= 1'b0;
            data_latch  <= 8'h00;
        end else if (rd_tick) begin
            second_byte <= 1'b0;
        end else if (wr_tick) begin
            second_byte <= ~second_byte;
            // Only the first byte is kept
            if (!second_byte) begin
                data_latch <= din;
            end
        end
    end

    // ******************************
    // Register file
    // ******************************

    // The write lands on the edge that samples the command byte
    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '0;
        end else if (wr_tick && !rd_tick && second_byte && din[CMD_REG_BIT]) begin
            case (reg_sel)
                0: regs.r0 <= data_latch;
                1: regs.r1 <= data_latch;
                2: regs.r2 <= data_latch;
                3: regs.r3 <= data_latch;
                4: regs.r4 <= data_latch;
                5: regs.r5 <= data_latch;
                6: regs.r6 <= data_latch;
                default: regs.r7 <= data_latch;
            endcase
        end
        // With the command bit clear the pair would set up the VRAM
        // address. There is no VRAM here, so the pair is simply dropped
    end

endmodule

/* verilog/vdp_irq.sv */
// VDP frame interrupt

`timescale 1ns/1ps

module vdp_irq (
    input  logic pxclk,
    input  logic arst_n,
    input  logic irq_tick,
    input  logic rd_tick,
    input  logic irq_en,
    output logic flag,
    output logic irq
);

    // ******************************
    // Frame flag
    // ******************************

    // The flag is raised by the end-of-frame strobe and dropped by a
    // status read. The read itself still sees the old value since the
    // status byte is built from the register output, not its next state
    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (irq_tick) begin
            // A frame end in the same cycle as a read must not be lost
            flag <= 1'b1;
        end else if (rd_tick) begin
            flag <= 1'b0;
        end
    end

    // ******************************
    // Interrupt output
    // ******************************

    // The flag is always visible in status, but only drives the
    // interrupt line while R1 enables it
    assign irq = flag & irq_en;

endmodule

/* verilog/vgasync.sv */
// VGA raster timing

`timescale 1ns/1ps

module vgasync (
    input  logic             pxclk,
    input  logic             arst_n,
    output vdp_pkg::raster_t raster,
    output logic             hsync,
    output logic             vsync,
    output logic             last_pixel
);

    import vdp_pkg::*;

    // Horizontal and vertical position in the 800x525 frame
    logic [CNT_W-1:0] h_cnt;
    logic [CNT_W-1:0] v_cnt;

    // High on the final column of every line
    logic line_end;

    assign line_end = (h_cnt == CNT_W'(H_TOTAL - 1));

    // ******************************
    // Counters
    // ******************************

    // The column steps on every pixel clock and wraps at the line end
    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // The row steps only when the column wraps
    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            v_cnt <= '0;
        end else if (line_end) begin
            if (v_cnt == CNT_W'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // ******************************
    // Decodes
    // ******************************

    // Position handed to the pixel logic
    assign raster.col        = h_cnt;
    assign raster.row        = v_cnt;
    assign raster.vid_active = (h_cnt < CNT_W'(H_ACTIVE)) && (v_cnt < CNT_W'(V_ACTIVE));

    // Both pulses are active low and sit right after the front porch
    // Horizontal sync covers columns 656 to 751
    assign hsync = !((h_cnt >= CNT_W'(H_ACTIVE + H_FRONT)) &&
                     (h_cnt <  CNT_W'(H_ACTIVE + H_FRONT + H_SYNC)));

    // Vertical sync covers rows 490 and 491
    assign vsync = !((v_cnt >= CNT_W'(V_ACTIVE + V_FRONT)) &&
                     (v_cnt <  CNT_W'(V_ACTIVE + V_FRONT + V_SYNC)));

    // One cycle strobe on the very last pixel of the frame
    assign last_pixel = line_end && (v_cnt == CNT_W'(V_TOTAL - 1));

endmodule

/* verilog/vdp_pixel.sv */
// VDP colour bar source

`timescale 1ns/1ps

module vdp_pixel (
    input  vdp_pkg::raster_t   raster,
    input  vdp_pkg::vdp_regs_t regs,
    output logic [3:0]         color
);

    import vdp_pkg::*;

    // Raster position falls inside the doubled 256x192 window
    logic in_win_x;
    logic in_win_y;

    // Column relative to the window's left edge
    logic [CNT_W-1:0] win_col;

    // Column in VDP pixels that are each two VGA pixels wide
    logic [CNT_W-2:0] pix_x;

    // Which of the eight 32 pixel bars is under the beam
    logic [$clog2(NUM_REGS)-1:0] bar_sel;

    // Colour of the bar taken from the selected register
    logic [3:0] bar_color;

    // ******************************
    // Window placement
    // ******************************

    assign in_win_x = (raster.col >= CNT_W'(WIN_X0)) &&
                      (raster.col <  CNT_W'(WIN_X0 + WIN_W));
    assign in_win_y = (raster.row >= CNT_W'(WIN_Y0)) &&
                      (raster.row <  CNT_W'(WIN_Y0 + WIN_H));

    assign win_col = raster.col - CNT_W'(WIN_X0);

    // Dropping the low bit undoes the horizontal doubling
    assign pix_x = win_col[CNT_W-1:1];

    // Top bits of the 0 to 255 index give the bar number
    assign bar_sel = pix_x[7 -: $clog2(NUM_REGS)];

    // ******************************
    // Colour choice
    // ******************************

    always_comb begin
        case (bar_sel)
            0: bar_color = regs.r0[3:0];
            1: bar_color = regs.r1[3:0];
            2: bar_color = regs.r2[3:0];
            3: bar_color = regs.r3[3:0];
            4: bar_color = regs.r4[3:0];
            5: bar_color = regs.r5[3:0];
            6: bar_color = regs.r6[3:0];
            default: bar_color = regs.r7[3:0];
        endcase
    end

    // Blanking area is black, the border and a blanked screen show the
    // backdrop colour, and the window shows the bars
    always_comb begin
        if (!raster.vid_active) begin
            color = 4'h0;
        end else if (in_win_x && in_win_y && regs.r1[R1_BLANK_BIT]) begin
            color = bar_color;
        end else begin
            color = regs.r7[3:0];
        end
    end

endmodule

/* verilog/vdp99.sv */
// VDP top level

`timescale 1ns/1ps

module vdp99 (
    input  logic       pxclk,
    input  logic       arst_n,
    input  logic       wr_tick,
    input  logic       rd_tick,
    input  logic       mode,
    input  logic [7:0] din,
    output logic [7:0] dout,
    output logic       irq,
    output logic [3:0] color,
    output logic       hsync,
    output logic       vsync
);

    import vdp_pkg::*;

    // Host strobes qualified for the control port
    logic wr_ctl;
    logic rd_ctl;

    // Register file contents
    vdp_regs_t regs;

    // Beam position from the timing block
    raster_t raster;

    // End-of-frame strobe and the latched frame flag
    logic last_pixel;
    logic frame_flag;

    // ******************************
    // Host port
    // ******************************

    // Mode high selects the control port, mode low the VRAM data port
    // which does not exist here, so those ticks are ignored
    assign wr_ctl = wr_tick & mode;
    assign rd_ctl = rd_tick & mode;

    // Status byte carries the frame flag in bit 7 and zeros below
    assign dout = rd_ctl ? {frame_flag, 7'b000_0000} : 8'h00;

    // ******************************
    // Blocks
    // ******************************

    vdp_reg_ifce i_reg_ifce (
        .pxclk   (pxclk),
        .arst_n  (arst_n),
        .wr_tick (wr_ctl),
        .rd_tick (rd_ctl),
        .din     (din),
        .regs    (regs)
    );

    vdp_irq i_irq (
        .pxclk    (pxclk),
        .arst_n   (arst_n),
        .irq_tick (last_pixel),
        .rd_tick  (rd_ctl),
        .irq_en   (regs.r1[R1_IE_BIT]),
        .flag     (frame_flag),
        .irq      (irq)
    );

    vgasync i_vgasync (
        .pxclk      (pxclk),
        .arst_n     (arst_n),
        .raster     (raster),
        .hsync      (hsync),
        .vsync      (vsync),
        .last_pixel (last_pixel)
    );

    vdp_pixel i_pixel (
        .raster (raster),
        .regs   (regs),
        .color  (color)
    );

endmodule

/* tb/vdp99_checker.sv */
// VDP port checker

`timescale 1ns/1ps

module vdp99_checker (
    input  logic       pxclk,
    input  logic       arst_n,
    input  logic       wr_tick,
    input  logic       rd_tick,
    input  logic       mode,
    input  logic [7:0] din,
    input  logic [7:0] dout,
    input  logic       irq,
    input  logic [3:0] color,
    input  logic       hsync,
    input  logic       vsync,
    output int         error_count,
    output int         checked_cycles,
    output logic       saw_flag_read
);

    import vdp_pkg::*;

    // Reference state of the VDP kept from the port activity alone
    logic [7:0] m_regs [0:NUM_REGS-1];
    logic       m_second;
    logic [7:0] m_latch;
    logic       m_flag;
    int         m_col;
    int         m_row;

    int   errors = 0;
    int   cycles = 0;
    logic flag_read = 1'b0;

    assign error_count    = errors;
    assign checked_cycles = cycles;
    assign saw_flag_read  = flag_read;

    // ******************************
    // Reference model
    // ******************************

    task automatic reset_model();
        for (int i = 0; i < NUM_REGS; i++) begin
            m_regs[i] = 8'h00;
        end
        m_second = 1'b0;
        m_latch  = 8'h00;
        m_flag   = 1'b0;
        m_col    = 0;
        m_row    = 0;
    endtask

    task automatic update_model();
        logic wr;
        logic rd;
        logic frame_end;
        // Ticks only reach the control port while mode is high
        wr = wr_tick & mode;
        rd = rd_tick & mode;
        frame_end = (m_col == H_TOTAL - 1) && (m_row == V_TOTAL - 1);
        // Frame end beats a status read in the same cycle
        if (frame_end) begin
            m_flag = 1'b1;
        end else if (rd) begin
            m_flag = 1'b0;
        end
        if (rd) begin
            m_second = 1'b0;
        end else if (wr) begin
            if (!m_second) begin
                m_latch = din;
            end else if (din[CMD_REG_BIT]) begin
                m_regs[din[2:0]] = m_latch;
            end
            m_second = !m_second;
        end
        if (m_col == H_TOTAL - 1) begin
            m_col = 0;
            m_row = (m_row == V_TOTAL - 1) ? 0 : m_row + 1;
        end else begin
            m_col = m_col + 1;
        end
    endtask

    // Border, bars, blanked window and the black blanking interval
    function automatic logic [3:0] expected_color();
        logic active;
        logic in_window;
        int   bar;
        active    = (m_col < H_ACTIVE) && (m_row < V_ACTIVE);
        in_window = (m_col >= WIN_X0) && (m_col < WIN_X0 + WIN_W) &&
                    (m_row >= WIN_Y0) && (m_row < WIN_Y0 + WIN_H);
        // A bar is 32 VDP pixels wide, so 64 columns once doubled
        bar = (m_col - WIN_X0) / 64;
        if (!active) begin
            expected_color = 4'h0;
        end else if (in_window && m_regs[1][R1_BLANK_BIT]) begin
            expected_color = m_regs[bar][3:0];
        end else begin
            expected_color = m_regs[7][3:0];
        end
    endfunction

    // ******************************
    // Comparison
    // ******************************

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // The model steps on the same edge as the DUT registers
    always @(posedge pxclk) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            update_model();
        end
    end

    // Outputs are compared mid-cycle, where all of them have settled
    always @(negedge pxclk) begin
        if (arst_n) begin
            cycles++;
            check_value("hsync", 8'(!(m_col >= 656 && m_col <= 751)), 8'(hsync));
            check_value("vsync", 8'(!(m_row == 490 || m_row == 491)), 8'(vsync));
            check_value("color", 8'(expected_color()), 8'(color));
            check_value("irq", 8'(m_flag & m_regs[1][R1_IE_BIT]), 8'(irq));
            if (rd_tick && mode) begin
                check_value("dout", {m_flag, 7'b000_0000}, dout);
                if (m_flag) begin
                    flag_read = 1'b1;
                end
            end else begin
                check_value("dout", 8'h00, dout);
            end
        end
    end

endmodule

/* tb/tb_vdp99.sv */
// VDP testbench top

`timescale 1ns/1ps

module tb_vdp99;

    import vdp_pkg::*;

    localparam int          CLK_HALF      = 5;
    localparam int          RESET_CYCLES  = 3;
    localparam int          DRIVE_DELAY   = 1;
    localparam int          RUN_FRAMES    = 3;
    localparam int          FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    // Three frames plus a third of a frame of slack
    localparam int          TIMEOUT_CYCLES = RUN_FRAMES * FRAME_CYCLES + FRAME_CYCLES / 3;
    localparam logic [31:0] LCG_SEED      = 32'h91d52a74;
    localparam logic [31:0] LCG_MUL       = 32'd1664525;
    localparam logic [31:0] LCG_INC       = 32'd1013904223;

    logic       pxclk;
    logic       arst_n;
    logic       wr_tick;
    logic       rd_tick;
    logic       mode;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq;
    logic [3:0] color;
    logic       hsync;
    logic       vsync;

    int          error_count;
    int          checked_cycles;
    logic        saw_flag_read;
    logic [31:0] rng_state = LCG_SEED;
    int          cycle_count = 0;
    int          frames_seen = 0;
    logic        vsync_prev = 1'b1;
    int          other_fails;

    vdp99 i_vdp99 (
        .pxclk   (pxclk),
        .arst_n  (arst_n),
        .wr_tick (wr_tick),
        .rd_tick (rd_tick),
        .mode    (mode),
        .din     (din),
        .dout    (dout),
        .irq     (irq),
        .color   (color),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    vdp99_checker i_vdp99_checker (
        .pxclk          (pxclk),
        .arst_n         (arst_n),
        .wr_tick        (wr_tick),
        .rd_tick        (rd_tick),
        .mode           (mode),
        .din            (din),
        .dout           (dout),
        .irq            (irq),
        .color          (color),
        .hsync          (hsync),
        .vsync          (vsync),
        .error_count    (error_count),
        .checked_cycles (checked_cycles),
        .saw_flag_read  (saw_flag_read)
    );

    always #CLK_HALF pxclk = ~pxclk;

    // ******************************
    // Stimulus helpers
    // ******************************

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * LCG_MUL + LCG_INC;
    endfunction

    // The low LCG bits cycle quickly, so only the upper 24 are handed out
    task automatic draw(output logic [31:0] value);
        rng_state = lcg_step(rng_state);
        value = {8'h00, rng_state[31:8]};
    endtask

    task automatic drive_cycle(input logic wr, input logic rd, input logic md,
                               input logic [7:0] data);
        @(posedge pxclk);
        #DRIVE_DELAY;
        wr_tick = wr;
        rd_tick = rd;
        mode    = md;
        din     = data;
    endtask

    // Idle cycles still wiggle mode and din to show that they are ignored
    task automatic idle_cycles(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            draw(r);
            drive_cycle(1'b0, 1'b0, r[0], r[15:8]);
        end
    endtask

    // One tick followed by one quiet cycle
    task automatic pulse(input logic wr, input logic rd, input logic md, input logic [7:0] data);
        drive_cycle(wr, rd, md, data);
        drive_cycle(1'b0, 1'b0, md, data);
    endtask

    task automatic write_pair(input logic [2:0] reg_num, input logic [7:0] data,
                              input logic [3:0] filler);
        pulse(1'b1, 1'b0, 1'b1, data);
        pulse(1'b1, 1'b0, 1'b1, {1'b1, filler, reg_num});
    endtask

    task automatic run_random_op();
        logic [31:0] r;
        logic [31:0] d;
        draw(r);
        draw(d);
        case (r[3:0])
            9, 10: begin
                // VRAM address setup where the second byte has bit 7 clear
                pulse(1'b1, 1'b0, 1'b1, d[7:0]);
                pulse(1'b1, 1'b0, 1'b1, {1'b0, d[14:8]});
            end
            11, 12: pulse(1'b0, 1'b1, 1'b1, d[7:0]);
            13: begin
                // A lone first byte that a status read throws away
                pulse(1'b1, 1'b0, 1'b1, d[7:0]);
                pulse(1'b0, 1'b1, 1'b1, d[7:0]);
                write_pair(r[6:4], d[15:8], d[19:16]);
            end
            14, 15: pulse(r[4], !r[4], 1'b0, d[7:0]);
            default: write_pair(r[6:4], d[7:0], d[11:8]);
        endcase
        idle_cycles(1 + int'(r[13:8]));
    endtask

    // ******************************
    // Run control
    // ******************************

    // Frames are counted on the rising edge of the DUT's vsync
    always @(negedge pxclk) begin
        if (arst_n && vsync && !vsync_prev) begin
            frames_seen++;
        end
        vsync_prev = vsync;
    end

    always @(posedge pxclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("closing: %0d value errors, 1 other failures", error_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        pxclk       = 1'b0;
        arst_n      = 1'b0;
        wr_tick     = 1'b0;
        rd_tick     = 1'b0;
        mode        = 1'b0;
        din         = 8'h00;
        other_fails = 0;
        repeat (RESET_CYCLES) @(posedge pxclk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        // Sixty quiet lines reach well into the window with every register at zero
        idle_cycles(60 * H_TOTAL);
        while (frames_seen < RUN_FRAMES) begin
            run_random_op();
        end
        idle_cycles(16);
        if (!saw_flag_read) begin
            $display("no status read returned a set frame flag during the run");
            other_fails++;
        end
        $display("closing: %0d value errors, %0d other failures, %0d cycles checked",
                 error_count, other_fails, checked_cycles);
        if (error_count == 0 && other_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/vdp_pkg.sv
verilog/vdp_reg_ifce.sv
verilog/vdp_irq.sv
verilog/vgasync.sv
verilog/vdp_pixel.sv
verilog/vdp99.sv
tb/vdp99_checker.sv
tb/tb_vdp99.sv

/* Bender.yml */
package:
  name: vdp99

sources:
  - verilog/vdp_pkg.sv
  - verilog/vdp_reg_ifce.sv
  - verilog/vdp_irq.sv
  - verilog/vgasync.sv
  - verilog/vdp_pixel.sv
  - verilog/vdp99.sv
  - target: test
    files:
      - tb/vdp99_checker.sv
      - tb/tb_vdp99.sv
